//--- sim.f
+incdir+src
src/lockstep_pkg.sv
src/sum_core.sv
src/shadow_reset_gen.sv
src/lockstep_delay_line.sv
src/lockstep_top.sv
test/lockstep_properties.sv
test/tb_lockstep.sv

//--- test/tb_lockstep.sv
/*
  Directed testbench for lockstep_top with a main sum_core beside it.
  The memory model answers after 0 to 2 random wait states.
  Faults are flipped only on the copies sent to the checker.
  The input fault test leaves the shadow sum different, so it runs last.
*/
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module tb_lockstep;

  import lockstep_pkg::*;

  localparam int    CLK_PERIOD  = 20;
  localparam int    NUM_TESTS   = 5;
  localparam int    JOB_CYCLES  = (`SUM_WORDS + 1) * 4 + `LOCKSTEP_OFFSET + 8;
  localparam int    WATCHDOG_NS = (NUM_TESTS * JOB_CYCLES * 2 + 8) * CLK_PERIOD;
  localparam word_t BOOT_ADDR   = 32'h0000_1000;
  localparam int    RESULT_IDX  = `RESULT_OFFSET / 4;
  localparam int    ERR_WORD    = 2;

  logic  clk_i;
  logic  rst_ni;
  logic  start;
  logic  main_cyc, main_stb, main_we, main_busy, main_alert_minor;
  word_t main_adr, main_wdata;
  sel_t  main_sel;
  logic  alert_major, alert_minor;

  // Memory model and fault injection
  word_t       mem [32];
  word_t       mem_rdata = '0;
  logic        mem_ack = 1'b0;
  logic        mem_err = 1'b0;
  word_t       dat_flip = '0;
  word_t       adr_flip;
  int unsigned wait_left;
  bit          pending = 1'b0;
  bit          corrupt_read = 1'b0;
  int          err_index = -1;
  integer      seed = 40;

  int cycle = 0;
  int major_count, minor_count, major_last, major_in_write, write_cycles;
  int minor_last, main_minor_last;
  int fault_cycle;
  int error_count = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int assert_fails;
  logic [`LOCKSTEP_OFFSET:0] we_hist = '0;

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  sum_core u_main (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .boot_addr_i   (BOOT_ADDR),
    .start_i       (start),
    .wb_cyc_o      (main_cyc),
    .wb_stb_o      (main_stb),
    .wb_we_o       (main_we),
    .wb_adr_o      (main_adr),
    .wb_dat_o      (main_wdata),
    .wb_sel_o      (main_sel),
    .wb_dat_i      (mem_rdata),
    .wb_ack_i      (mem_ack),
    .wb_err_i      (mem_err),
    .busy_o        (main_busy),
    .alert_minor_o (main_alert_minor)
  );

  lockstep_top uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .boot_addr_i     (BOOT_ADDR),
    .core_start_i    (start),
    .core_wb_dat_i   (mem_rdata ^ dat_flip),
    .core_wb_ack_i   (mem_ack),
    .core_wb_err_i   (mem_err),
    .core_wb_cyc_i   (main_cyc),
    .core_wb_stb_i   (main_stb),
    .core_wb_we_i    (main_we),
    .core_wb_adr_i   (main_adr ^ adr_flip),
    .core_wb_dat_o_i (main_wdata),
    .core_wb_sel_i   (main_sel),
    .core_busy_i     (main_busy),
    .alert_major_o   (alert_major),
    .alert_minor_o   (alert_minor)
  );

  //////////////////////////////////////////////////
  // Wishbone memory model
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_ack   <= 1'b0;
      mem_err   <= 1'b0;
      mem_rdata <= '0;
      dat_flip  <= '0;
      pending   = 1'b0;
    end else if (mem_ack || mem_err) begin
      // Response lasts one cycle
      mem_ack  <= 1'b0;
      mem_err  <= 1'b0;
      dat_flip <= '0;
    end else if (main_cyc && main_stb) begin
      if (!pending) begin
        wait_left = {$random(seed)} % 3;
        pending   = 1'b1;
      end
      if (wait_left == 0) begin
        pending = 1'b0;
        if (main_we) begin
          mem[main_adr[6:2]] <= main_wdata;
          mem_ack <= 1'b1;
        end else if (int'(main_adr[6:2]) == err_index) begin
          mem_err <= 1'b1;
        end else begin
          mem_rdata <= mem[main_adr[6:2]];
          mem_ack   <= 1'b1;
          if (corrupt_read) begin
            dat_flip <= word_t'(1) << 7;
            corrupt_read = 1'b0;
          end
        end
      end else begin
        wait_left--;
      end
    end
  end

  //////////////////////////////////////////////////
  // Alert monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(posedge clk_i) cycle <= cycle + 1;

  always @(negedge clk_i) begin
    // Bit OFFSET is the main core's write strobe from OFFSET cycles ago
    we_hist = {we_hist[`LOCKSTEP_OFFSET-1:0], main_we};
    if (we_hist[`LOCKSTEP_OFFSET]) write_cycles++;
    if (alert_major === 1'b1) begin
      major_count++;
      major_last = cycle;
      if (we_hist[`LOCKSTEP_OFFSET]) major_in_write++;
    end
    if (alert_minor === 1'b1) begin
      minor_count++;
      minor_last = cycle;
    end
    if (main_alert_minor === 1'b1) main_minor_last = cycle;
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic clear_counters();
    major_count     = 0;
    minor_count     = 0;
    major_last      = -1;
    major_in_write  = 0;
    write_cycles    = 0;
    minor_last      = -1;
    main_minor_last = -1;
  endtask

  // Random job words, result slot preset to a wrong value
  task automatic load_words(input int skip, output word_t expected);
    expected = '0;
    for (int k = 0; k < `SUM_WORDS; k++) begin
      mem[k] = $random(seed);
      if (k != skip) expected += mem[k];
    end
    mem[RESULT_IDX] = ~expected;
  endtask

  task automatic run_job(input bit adr_fault);
    int n;
    bit done;
    n    = 0;
    done = 1'b0;
    @(posedge clk_i);
    start <= 1'b1;
    @(posedge clk_i);
    start <= 1'b0;
    if (adr_fault) adr_flip <= word_t'(1) << 4;
    @(negedge clk_i);
    fault_cycle = cycle;
    if (adr_fault && !(main_cyc && !main_we)) begin
      error_count++;
      $display("Address fault was not injected during a read");
    end
    @(posedge clk_i);
    adr_flip <= '0;
    while (!done && n < JOB_CYCLES) begin
      @(negedge clk_i);
      done = !main_busy;
      n++;
    end
    if (!done) begin
      error_count++;
      $display("Job did not finish within %0d cycles", JOB_CYCLES);
    end
    // Shadow trails by the offset, one more for the last compare
    repeat (`LOCKSTEP_OFFSET + 1) @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_behavior();
    int errs;
    errs = error_count;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      if (alert_major !== 1'b0 || alert_minor !== 1'b0) begin
        report_error("alert not low during reset");
      end
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < `LOCKSTEP_OFFSET; i++) begin
      @(negedge clk_i);
      if (alert_major !== 1'b0 || alert_minor !== 1'b0) begin
        report_error("alert not low before the shadow core is released");
      end
    end
    end_test("reset", errs);
  endtask

  task automatic clean_job();
    int    errs;
    word_t expected;
    errs = error_count;
    @(posedge clk_i);
    load_words(-1, expected);
    clear_counters();
    run_job(1'b0);
    if (mem[RESULT_IDX] !== expected) begin
      report_error($sformatf("sum 0x%h, expected 0x%h", mem[RESULT_IDX], expected));
    end
    if (major_count != 0 || minor_count != 0) begin
      report_error($sformatf("alerts %0d/%0d, expected none", major_count, minor_count));
    end
    end_test("clean job", errs);
  endtask

  task automatic output_fault();
    int    errs;
    word_t expected;
    errs = error_count;
    @(posedge clk_i);
    load_words(-1, expected);
    clear_counters();
    run_job(1'b1);
    if (mem[RESULT_IDX] !== expected) begin
      report_error($sformatf("sum 0x%h, expected 0x%h", mem[RESULT_IDX], expected));
    end
    if (major_count != 1) begin
      report_error($sformatf("major alert high %0d cycles, expected 1", major_count));
    end
    if (major_last != fault_cycle + `LOCKSTEP_OFFSET) begin
      report_error($sformatf("major alert in cycle %0d, expected %0d", major_last,
                             fault_cycle + `LOCKSTEP_OFFSET));
    end
    end_test("output fault", errs);
  endtask

  task automatic bus_error_job();
    int    errs;
    word_t expected;
    errs = error_count;
    @(posedge clk_i);
    load_words(ERR_WORD, expected);
    err_index = ERR_WORD;
    clear_counters();
    run_job(1'b0);
    err_index = -1;
    if (mem[RESULT_IDX] !== expected) begin
      report_error($sformatf("sum 0x%h, expected 0x%h", mem[RESULT_IDX], expected));
    end
    if (minor_count != 1) begin
      report_error($sformatf("minor alert pulsed %0d cycles, expected 1", minor_count));
    end
    if (main_minor_last < 0 || minor_last != main_minor_last + `LOCKSTEP_OFFSET) begin
      report_error($sformatf("minor alert in cycle %0d, main core pulse in cycle %0d",
                             minor_last, main_minor_last));
    end
    if (major_count != 0) begin
      report_error($sformatf("major alert high %0d cycles, expected 0", major_count));
    end
    end_test("bus error", errs);
  endtask

  task automatic input_fault();
    int    errs;
    word_t expected;
    errs = error_count;
    @(posedge clk_i);
    load_words(-1, expected);
    corrupt_read = 1'b1;
    clear_counters();
    run_job(1'b0);
    if (mem[RESULT_IDX] !== expected) begin
      report_error($sformatf("sum 0x%h, expected 0x%h", mem[RESULT_IDX], expected));
    end
    if (write_cycles == 0) begin
      error_count++;
      $display("No delayed write cycle was seen in the input fault job");
    end
    if (major_in_write != write_cycles) begin
      report_error($sformatf("major alert in %0d of %0d delayed write cycles",
                             major_in_write, write_cycles));
    end
    end_test("input fault", errs);
  endtask

  initial begin
    rst_ni   = 1'b0;
    start    = 1'b0;
    adr_flip = '0;
    reset_behavior();
    clean_job();
    output_fault();
    bus_error_job();
    input_fault();
    assert_fails = uut.u_props.assert_failures;
    if (assert_fails != 0) begin
      $display("%0d assertion failures in the bound properties", assert_fails);
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
             error_count + assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- test/lockstep_properties.sv
/*
  Concurrent checks on the lockstep checker, bound into lockstep_top.
  Assumes rst_ni is low at the start of simulation.
  assert_failures counts failed assertions for the testbench summary.
*/
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module lockstep_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic shadow_rst_ni,
  input logic alert_major_i,
  input logic shadow_cyc_i,
  input logic shadow_stb_i
);

  import lockstep_pkg::*;

  offset_cnt_t since_release;
  int unsigned assert_failures = 0;

  // Rising edges seen with rst_ni high, saturating at the offset
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_release <= '0;
    end else if (since_release != offset_cnt_t'(`LOCKSTEP_OFFSET)) begin
      since_release <= since_release + offset_cnt_t'(1);
    end
  end

  shadow_release_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    shadow_rst_ni == (since_release == offset_cnt_t'(`LOCKSTEP_OFFSET)))
    else begin
      assert_failures++;
      $error("shadow reset not released exactly the lockstep offset after reset");
    end

  alert_gated_a: assert property (@(posedge clk_i) !shadow_rst_ni |-> !alert_major_i)
    else begin
      assert_failures++;
      $error("major alert high while the shadow core is in reset");
    end

  // Shadow bus protocol
  stb_needs_cyc_a: assert property (@(posedge clk_i) disable iff (!shadow_rst_ni)
    shadow_stb_i |-> shadow_cyc_i)
    else begin
      assert_failures++;
      $error("shadow core drives stb without cyc");
    end

endmodule

bind lockstep_top lockstep_properties u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .shadow_rst_ni (shadow_rst_n),
  .alert_major_i (alert_major_o),
  .shadow_cyc_i  (shadow_wb_cyc),
  .shadow_stb_i  (shadow_wb_stb)
);

//--- src/lockstep_top.sv
/*
  Lockstep checker for sum_core.
  Runs a shadow sum_core LOCKSTEP_OFFSET cycles behind the main core and
  compares its outputs with the delayed main-core outputs.
  boot_addr_i goes to the shadow core undelayed and must be static.
  alert_major_o is combinational from registers and delay lines.
*/
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module lockstep_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  lockstep_pkg::word_t  boot_addr_i,

  // Main core inputs
  input  logic                 core_start_i,
  input  lockstep_pkg::word_t  core_wb_dat_i,
  input  logic                 core_wb_ack_i,
  input  logic                 core_wb_err_i,

  // Main core outputs
  input  logic                 core_wb_cyc_i,
  input  logic                 core_wb_stb_i,
  input  logic                 core_wb_we_i,
  input  lockstep_pkg::word_t  core_wb_adr_i,
  input  lockstep_pkg::word_t  core_wb_dat_o_i,
  input  lockstep_pkg::sel_t   core_wb_sel_i,
  input  logic                 core_busy_i,

  output logic                 alert_major_o,
  output logic                 alert_minor_o
);

  import lockstep_pkg::*;

  localparam int unsigned IN_W  = `XLEN + 3;
  localparam int unsigned OUT_W = 2 * `XLEN + `SEL_W + 4;

  //////////////////////////////////////////////////
  // Reset generation
  //////////////////////////////////////////////////

  logic shadow_rst_n;

  shadow_reset_gen u_rst_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n)
  );

  //////////////////////////////////////////////////
  // Input and output delays
  //////////////////////////////////////////////////

  logic [IN_W-1:0]  core_inputs;
  logic [IN_W-1:0]  shadow_inputs;
  logic [OUT_W-1:0] core_outputs;
  logic [OUT_W-1:0] core_outputs_q;

  assign core_inputs = {core_start_i, core_wb_dat_i, core_wb_ack_i, core_wb_err_i};

  // Field order here must match shadow_outputs below
  assign core_outputs = {core_wb_cyc_i, core_wb_stb_i, core_wb_we_i, core_wb_adr_i,
                         core_wb_dat_o_i, core_wb_sel_i, core_busy_i};

  lockstep_delay_line #(
    .WIDTH (IN_W)
  ) u_in_delay (
    .clk_i  (clk_i),
    .data_i (core_inputs),
    .data_o (shadow_inputs)
  );

  lockstep_delay_line #(
    .WIDTH (OUT_W)
  ) u_out_delay (
    .clk_i  (clk_i),
    .data_i (core_outputs),
    .data_o (core_outputs_q)
  );

  //////////////////////////////////////////////////
  // Shadow core
  //////////////////////////////////////////////////

  logic  shadow_start;
  word_t shadow_wb_rdata;
  logic  shadow_wb_ack;
  logic  shadow_wb_err;

  logic  shadow_wb_cyc;
  logic  shadow_wb_stb;
  logic  shadow_wb_we;
  word_t shadow_wb_adr;
  word_t shadow_wb_wdata;
  sel_t  shadow_wb_sel;
  logic  shadow_busy;
  logic  shadow_alert_minor;

  logic [OUT_W-1:0] shadow_outputs;

  assign {shadow_start, shadow_wb_rdata, shadow_wb_ack, shadow_wb_err} = shadow_inputs;

  sum_core u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (shadow_rst_n),
    .boot_addr_i   (boot_addr_i),
    .start_i       (shadow_start),
    .wb_cyc_o      (shadow_wb_cyc),
    .wb_stb_o      (shadow_wb_stb),
    .wb_we_o       (shadow_wb_we),
    .wb_adr_o      (shadow_wb_adr),
    .wb_dat_o      (shadow_wb_wdata),
    .wb_sel_o      (shadow_wb_sel),
    .wb_dat_i      (shadow_wb_rdata),
    .wb_ack_i      (shadow_wb_ack),
    .wb_err_i      (shadow_wb_err),
    .busy_o        (shadow_busy),
    .alert_minor_o (shadow_alert_minor)
  );

  assign shadow_outputs = {shadow_wb_cyc, shadow_wb_stb, shadow_wb_we, shadow_wb_adr,
                           shadow_wb_wdata, shadow_wb_sel, shadow_busy};

  //////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////

  // Delay line holds junk until the shadow core is out of reset
  assign alert_major_o = shadow_rst_n & (shadow_outputs != core_outputs_q);
  assign alert_minor_o = shadow_alert_minor;

endmodule

//--- src/lockstep_delay_line.sv
/*
  Delays a flat bus by exactly LOCKSTEP_OFFSET cycles.
  No reset, so the output is unknown for the first LOCKSTEP_OFFSET cycles.
  Users must ignore it until then.
*/
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module lockstep_delay_line #(
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  // Entry 0 is the oldest
  logic [WIDTH-1:0] stage_q [`LOCKSTEP_OFFSET];

  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < `LOCKSTEP_OFFSET - 1; i++) begin
      stage_q[i] <= stage_q[i+1];
    end
    stage_q[`LOCKSTEP_OFFSET-1] <= data_i;
  end

  assign data_o = stage_q[0];

endmodule

//--- src/shadow_reset_gen.sv
/*
  Releases the shadow core's reset LOCKSTEP_OFFSET cycles after the system.
  The output is registered and drops asynchronously with rst_ni.
*/
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module shadow_reset_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no
);

  import lockstep_pkg::*;

  offset_cnt_t cnt_d, cnt_q;
  logic        set_d, set_q;

  // Count up once, then hold
  assign set_d = (cnt_q == offset_cnt_t'(`LOCKSTEP_OFFSET - 1));
  assign cnt_d = set_d ? cnt_q : (cnt_q + offset_cnt_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      set_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      set_q <= set_d;
    end
  end

  assign shadow_rst_no = set_q;

endmodule

//--- src/sum_core.sv
/*
  Wishbone classic bus master that sums a block of words.
  A start pulse reads SUM_WORDS words from boot_addr_i upward, then writes
  the 32-bit wrapped sum to boot_addr_i + RESULT_OFFSET.
  A read ending in err adds zero and pulses alert_minor_o in that cycle.
  boot_addr_i must stay constant while a job runs.
  start_i is ignored while busy.
*/
`timescale 1ns/1ps
`include "lockstep_settings.svh"

module sum_core (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  lockstep_pkg::word_t  boot_addr_i,
  input  logic                 start_i,

  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output lockstep_pkg::word_t  wb_adr_o,
  output lockstep_pkg::word_t  wb_dat_o,
  output lockstep_pkg::sel_t   wb_sel_o,
  input  lockstep_pkg::word_t  wb_dat_i,
  input  logic                 wb_ack_i,
  input  logic                 wb_err_i,

  output logic                 busy_o,
  output logic                 alert_minor_o
);

  import lockstep_pkg::*;

  localparam int unsigned CNT_W = (`SUM_WORDS > 1) ? $clog2(`SUM_WORDS) : 1;

  core_state_e      state_d, state_q;
  logic [CNT_W-1:0] word_cnt_d, word_cnt_q;
  word_t            sum_d, sum_q;

  logic             bus_done;
  logic             last_word;
  word_t            rd_adr;
  word_t            wr_adr;

  // Transfer ends on either ack or err
  assign bus_done  = wb_ack_i | wb_err_i;
  assign last_word = (word_cnt_q == CNT_W'(`SUM_WORDS - 1));

  assign rd_adr = boot_addr_i + (word_t'(word_cnt_q) << 2);
  assign wr_adr = boot_addr_i + word_t'(`RESULT_OFFSET);

  //////////////////////////////////////////////////
  // Job sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    word_cnt_d = word_cnt_q;
    sum_d      = sum_q;

    unique case (state_q)
      CS_IDLE: begin
        if (start_i) begin
          state_d    = CS_READ;
          word_cnt_d = '0;
          sum_d      = '0;
        end
      end

      CS_READ: begin
        if (bus_done) begin
          // Errored word counts as zero
          if (!wb_err_i) begin
            sum_d = sum_q + wb_dat_i;
          end
          if (last_word) begin
            state_d = CS_WRITE;
          end else begin
            word_cnt_d = word_cnt_q + CNT_W'(1);
          end
        end
      end

      CS_WRITE: begin
        if (bus_done) begin
          state_d = CS_IDLE;
        end
      end

      default: begin
        state_d = CS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= CS_IDLE;
      word_cnt_q <= '0;
      sum_q      <= '0;
    end else begin
      state_q    <= state_d;
      word_cnt_q <= word_cnt_d;
      sum_q      <= sum_d;
    end
  end

  //////////////////////////////////////////////////
  // Bus outputs
  //////////////////////////////////////////////////

  // Back-to-back reads keep cyc and stb high, the address just moves on
  assign wb_cyc_o = (state_q != CS_IDLE);
  assign wb_stb_o = (state_q != CS_IDLE);
  assign wb_we_o  = (state_q == CS_WRITE);
  assign wb_adr_o = (state_q == CS_WRITE) ? wr_adr : rd_adr;
  assign wb_dat_o = sum_q;

  // Full-word accesses only
  assign wb_sel_o = '1;

  // Low again in the cycle after the write is acknowledged
  assign busy_o = (state_q != CS_IDLE);

  assign alert_minor_o = (state_q == CS_READ) & wb_err_i;

endmodule

//--- src/lockstep_pkg.sv
/*
  Shared types for the lockstep checker.
  Widths follow lockstep_settings.svh.
*/
`include "lockstep_settings.svh"

package lockstep_pkg;

  // One bus word, used for both addresses and data
  typedef logic [`XLEN-1:0] word_t;

  // Wishbone byte select
  typedef logic [`SEL_W-1:0] sel_t;

  // Wide enough to hold LOCKSTEP_OFFSET itself
  typedef logic [$clog2(`LOCKSTEP_OFFSET + 1)-1:0] offset_cnt_t;

  // sum_core job sequence
  typedef enum logic [1:0] {
    CS_IDLE  = 2'd0,
    CS_READ  = 2'd1,
    CS_WRITE = 2'd2
  } core_state_e;

endpackage

//--- src/lockstep_settings.svh
/*
  Build-time settings for the lockstep checker and its core.
  LOCKSTEP_OFFSET must be 2 or more.
  XLEN and SEL_W must keep XLEN == 8 * SEL_W.
*/
`ifndef LOCKSTEP_SETTINGS_SVH
`define LOCKSTEP_SETTINGS_SVH

// Cycles the shadow core lags the main core
`define LOCKSTEP_OFFSET 2

// Bus geometry
`define XLEN  32
`define SEL_W 4

// Words summed per job
`define SUM_WORDS 4

// Byte offset of the result from the boot address
`define RESULT_OFFSET 64

`endif
